// File: rv_core_macros.svh
/* RV32I core widths and opcodes */

`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// ====================
// Widths and sizes
`define RV_XLEN      32
`define RV_NUM_REGS  32
`define RV_REG_AW    5
`define RV_RESET_PC  32'h0000_0000

// ADDI x0, x0, 0
`define RV_NOP       32'h0000_0013

// ====================
// Major opcodes
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111

`endif

// File: rv_core_pkg.sv
/* RV32I core types */

`default_nettype none
`include "rv_core_macros.svh"

package rv_core_pkg;

   // ====================
   // Decode selections
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_LT_S, ALU_LT_U, ALU_EQ, ALU_NE, ALU_GE_S, ALU_GE_U,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic {PORTA_RS1, PORTA_PC_EXE} porta_sel_e;
   typedef enum logic {PORTB_RS2, PORTB_IMM} portb_sel_e;
   typedef enum logic [1:0] {WB_ALU, WB_DATAMEM, WB_PC_PLUS4} wb_sel_e;
   typedef enum logic [1:0] {PC_PLUS4, PC_COND_BRANCH, PC_JUMP_ALU} pc_sel_e;

   // Pipeline state
   typedef enum logic [1:0] {
      PSTATE_RESET, PSTATE_CONT, PSTATE_BRANCH, PSTATE_WAITLD
   } pstate_e;

   typedef struct packed {
      alu_op_e                alu_op;
      porta_sel_e             porta_sel;
      portb_sel_e             portb_sel;
      wb_sel_e                wb_sel;
      pc_sel_e                pc_sel;
      logic                   reg_write;
      logic                   mem_read;
      logic                   mem_write;
      logic [`RV_REG_AW-1:0]  rs1;
      logic [`RV_REG_AW-1:0]  rs2;
      logic [`RV_REG_AW-1:0]  rd;
   } ctrl_t;

   // ====================
   // Memory ports
   typedef struct packed {
      logic [`RV_XLEN-1:0] addr;
      logic                req;
   } code_req_t;

   typedef struct packed {
      logic [`RV_XLEN-1:0] rdata;
      logic                ready;
   } code_rsp_t;

   typedef struct packed {
      logic [`RV_XLEN-1:0] addr;
      logic [`RV_XLEN-1:0] wdata;
      logic [3:0]          bytesel;
      logic                req;
   } data_req_t;

   typedef struct packed {
      logic [`RV_XLEN-1:0] rdata;
      logic                ready;
   } data_rsp_t;

endpackage

`default_nettype wire

// File: rv_decoder.sv
/* Instruction decoder */

`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_decoder import rv_core_pkg::*; (
   input  logic [`RV_XLEN-1:0] instr,
   output ctrl_t               ctrl,
   output logic [`RV_XLEN-1:0] imm
);

   logic [6:0]          opcode;
   logic [2:0]          funct3;
   logic [6:0]          funct7;
   logic                funct7_ok;
   logic [`RV_XLEN-1:0] imm_i;
   logic [`RV_XLEN-1:0] imm_s;
   logic [`RV_XLEN-1:0] imm_b;
   logic [`RV_XLEN-1:0] imm_u;
   logic [`RV_XLEN-1:0] imm_j;

   // Shared by OP and OP-IMM, alt picks SUB or SRA
   function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  return alt ? ALU_SUB : ALU_ADD;
         3'b001:  return ALU_SLL;
         3'b010:  return ALU_LT_S;
         3'b011:  return ALU_LT_U;
         3'b100:  return ALU_XOR;
         3'b101:  return alt ? ALU_SRA : ALU_SRL;
         3'b110:  return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   // Only bit 30 may be set in a base-ISA funct7
   assign funct7_ok = (funct7 & 7'b1011111) == 7'b0;

   // ====================
   // Immediate formats
   assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
   assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{(`RV_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      // No-op unless a case below claims the instruction
      ctrl.alu_op    = ALU_ADD;
      ctrl.porta_sel = PORTA_RS1;
      ctrl.portb_sel = PORTB_RS2;
      ctrl.wb_sel    = WB_ALU;
      ctrl.pc_sel    = PC_PLUS4;
      ctrl.reg_write = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.rs1       = instr[19:15];
      ctrl.rs2       = instr[24:20];
      ctrl.rd        = instr[11:7];
      imm            = imm_i;
      case (opcode)
         `RV_OPC_OP: begin
            ctrl.alu_op    = arith_op(funct3, funct7[5]);
            ctrl.reg_write = funct7_ok;
         end
         `RV_OPC_OP_IMM: begin
            ctrl.alu_op    = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
            ctrl.portb_sel = PORTB_IMM;
            ctrl.reg_write = 1'b1;
         end
         `RV_OPC_LUI, `RV_OPC_AUIPC: begin
            ctrl.alu_op    = (opcode == `RV_OPC_LUI) ? ALU_PASS_B : ALU_ADD;
            ctrl.porta_sel = PORTA_PC_EXE;
            ctrl.portb_sel = PORTB_IMM;
            ctrl.reg_write = 1'b1;
            imm            = imm_u;
         end
         `RV_OPC_JAL, `RV_OPC_JALR: begin
            if (opcode == `RV_OPC_JAL || funct3 == 3'b000) begin
               ctrl.porta_sel = (opcode == `RV_OPC_JAL) ? PORTA_PC_EXE : PORTA_RS1;
               ctrl.portb_sel = PORTB_IMM;
               ctrl.wb_sel    = WB_PC_PLUS4;
               ctrl.pc_sel    = PC_JUMP_ALU;
               ctrl.reg_write = 1'b1;
            end
            imm = (opcode == `RV_OPC_JAL) ? imm_j : imm_i;
         end
         `RV_OPC_BRANCH: begin
            imm         = imm_b;
            ctrl.pc_sel = PC_COND_BRANCH;
            case (funct3)
               3'b000:  ctrl.alu_op = ALU_EQ;
               3'b001:  ctrl.alu_op = ALU_NE;
               3'b100:  ctrl.alu_op = ALU_LT_S;
               3'b101:  ctrl.alu_op = ALU_GE_S;
               3'b110:  ctrl.alu_op = ALU_LT_U;
               3'b111:  ctrl.alu_op = ALU_GE_U;
               default: ctrl.pc_sel = PC_PLUS4;
            endcase
         end
         `RV_OPC_LOAD, `RV_OPC_STORE: begin
            // Word access only
            ctrl.portb_sel = PORTB_IMM;
            ctrl.wb_sel    = WB_DATAMEM;
            ctrl.mem_read  = (opcode == `RV_OPC_LOAD) && funct3 == 3'b010;
            ctrl.reg_write = (opcode == `RV_OPC_LOAD) && funct3 == 3'b010;
            ctrl.mem_write = (opcode == `RV_OPC_STORE) && funct3 == 3'b010;
            imm            = (opcode == `RV_OPC_STORE) ? imm_s : imm_i;
         end
         default: begin
            imm = imm_i;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rv_alu.sv
/* Integer ALU */

`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_alu import rv_core_pkg::*; (
   input  alu_op_e             alu_op,
   input  logic [`RV_XLEN-1:0] porta,
   input  logic [`RV_XLEN-1:0] portb,
   output logic [`RV_XLEN-1:0] alu_res,
   output logic                alu_cond
);

   logic [4:0] shamt;
   logic       lt_s;
   logic       lt_u;
   logic       eq;

   assign shamt = portb[4:0];
   assign lt_s  = $signed(porta) < $signed(portb);
   assign lt_u  = porta < portb;
   assign eq    = porta == portb;

   // Compare flag, also feeds SLT and SLTU
   always_comb begin
      case (alu_op)
         ALU_LT_S: alu_cond = lt_s;
         ALU_LT_U: alu_cond = lt_u;
         ALU_EQ:   alu_cond = eq;
         ALU_NE:   alu_cond = !eq;
         ALU_GE_S: alu_cond = !lt_s;
         ALU_GE_U: alu_cond = !lt_u;
         default:  alu_cond = 1'b0;
      endcase
   end

   always_comb begin
      case (alu_op)
         ALU_ADD:    alu_res = porta + portb;
         ALU_SUB:    alu_res = porta - portb;
         ALU_AND:    alu_res = porta & portb;
         ALU_OR:     alu_res = porta | portb;
         ALU_XOR:    alu_res = porta ^ portb;
         ALU_SLL:    alu_res = porta << shamt;
         ALU_SRL:    alu_res = porta >> shamt;
         ALU_SRA:    alu_res = $signed(porta) >>> shamt;
         ALU_PASS_B: alu_res = portb;
         default:    alu_res = {{(`RV_XLEN-1){1'b0}}, alu_cond};
      endcase
   end

endmodule

`default_nettype wire

// File: rv_regfile.sv
/* Register file */

`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_regfile #(
   parameter int NUM_REGS = `RV_NUM_REGS
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`RV_REG_AW-1:0] sel_porta,
   input  logic [`RV_REG_AW-1:0] sel_portb,
   input  logic [`RV_REG_AW-1:0] sel_rd,
   input  logic [`RV_XLEN-1:0]   rd,
   input  logic                  write_rd,
   output logic [`RV_XLEN-1:0]   porta,
   output logic [`RV_XLEN-1:0]   portb
);

   logic [`RV_XLEN-1:0] regs [NUM_REGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (write_rd && sel_rd != '0 && int'(sel_rd) < NUM_REGS) begin
         regs[sel_rd] <= rd;
      end
   end

   // x0 and indexes past the array read as zero
   assign porta = (sel_porta == '0 || int'(sel_porta) >= NUM_REGS) ? '0 : regs[sel_porta];
   assign portb = (sel_portb == '0 || int'(sel_portb) >= NUM_REGS) ? '0 : regs[sel_portb];

endmodule

`default_nettype wire

// File: rv_flow_ctrl.sv
/* Pipeline flow control */

`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_flow_ctrl import rv_core_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  code_rsp_t           code_rsp,
   input  logic                data_ready,
   input  pc_sel_e             pc_sel,
   input  logic                mem_read,
   input  logic                alu_cond,
   input  logic [`RV_XLEN-1:0] alu_res,
   input  logic [`RV_XLEN-1:0] imm,
   output logic [`RV_XLEN-1:0] instr,
   output logic [`RV_XLEN-1:0] pc_exe,
   output logic [`RV_XLEN-1:0] fetch_addr,
   output logic                stall_exe
);

   pstate_e             pstate_r;
   pstate_e             pstate_next;
   logic [`RV_XLEN-1:0] pc_fetch_r;
   logic [`RV_XLEN-1:0] seq_addr;
   logic [`RV_XLEN-1:0] target;
   logic                branch_taken;
   logic                take_instr;

   assign branch_taken = (pc_sel == PC_JUMP_ALU) || (pc_sel == PC_COND_BRANCH && alu_cond);
   assign target = (pc_sel == PC_JUMP_ALU) ? {alu_res[`RV_XLEN-1:1], 1'b0} : pc_exe + imm;
   assign seq_addr = pc_fetch_r + `RV_XLEN'(4);

   // ====================
   // State machine
   always_comb begin
      // Default holds the fetch address and reissues the word in flight
      pstate_next = pstate_r;
      stall_exe   = 1'b1;
      take_instr  = 1'b0;
      fetch_addr  = pc_fetch_r;
      case (pstate_r)
         PSTATE_RESET: begin
            fetch_addr  = `RV_RESET_PC;
            pstate_next = PSTATE_BRANCH;
         end
         PSTATE_CONT, PSTATE_WAITLD: begin
            if (mem_read && !data_ready) begin
               pstate_next = PSTATE_WAITLD;
            end else begin
               stall_exe = 1'b0;
               if (branch_taken) begin
                  fetch_addr  = target;
                  pstate_next = PSTATE_BRANCH;
               end else if (code_rsp.ready) begin
                  take_instr  = 1'b1;
                  fetch_addr  = seq_addr;
                  pstate_next = PSTATE_CONT;
               end else begin
                  // Next word is late so the stage runs empty until it lands
                  pstate_next = PSTATE_BRANCH;
               end
            end
         end
         default: begin
            // Refill waits for the word at pc_fetch_r
            if (code_rsp.ready) begin
               take_instr  = 1'b1;
               fetch_addr  = seq_addr;
               pstate_next = PSTATE_CONT;
            end
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pstate_r   <= PSTATE_RESET;
         pc_fetch_r <= `RV_RESET_PC;
         pc_exe     <= `RV_RESET_PC;
         instr      <= `RV_NOP;
      end else begin
         pstate_r   <= pstate_next;
         pc_fetch_r <= fetch_addr;
         if (take_instr) begin
            instr  <= code_rsp.rdata;
            pc_exe <= pc_fetch_r;
         end else if (!stall_exe) begin
            // Executed word retires and a bubble takes its place
            instr <= `RV_NOP;
         end
      end
   end

endmodule

`default_nettype wire

// File: rv_core.sv
/* RV32I two-stage core */

`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_core import rv_core_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   output code_req_t code_req,
   input  code_rsp_t code_rsp,
   output data_req_t data_req,
   input  data_rsp_t data_rsp
);

   ctrl_t               ctrl;
   logic [`RV_XLEN-1:0] instr;
   logic [`RV_XLEN-1:0] imm;
   logic [`RV_XLEN-1:0] pc_exe;
   logic [`RV_XLEN-1:0] fetch_addr;
   logic                stall_exe;
   logic [`RV_XLEN-1:0] rf_porta;
   logic [`RV_XLEN-1:0] rf_portb;
   logic [`RV_XLEN-1:0] alu_porta;
   logic [`RV_XLEN-1:0] alu_portb;
   logic [`RV_XLEN-1:0] alu_res;
   logic                alu_cond;
   logic [`RV_XLEN-1:0] rd_data;
   logic                write_rd;
   logic                store_en;

   // ====================
   // Operands and write-back
   assign alu_porta = (ctrl.porta_sel == PORTA_PC_EXE) ? pc_exe : rf_porta;
   assign alu_portb = (ctrl.portb_sel == PORTB_IMM) ? imm : rf_portb;

   always_comb begin
      case (ctrl.wb_sel)
         WB_DATAMEM:  rd_data = data_rsp.rdata;
         WB_PC_PLUS4: rd_data = pc_exe + `RV_XLEN'(4);
         default:     rd_data = alu_res;
      endcase
   end

   assign write_rd = ctrl.reg_write && !stall_exe;
   assign store_en = ctrl.mem_write && !stall_exe;

   // ====================
   // Memory ports
   always_comb begin
      code_req.addr    = fetch_addr;
      code_req.req     = 1'b1;
      // Load request stays up through the wait, stores fire once
      data_req.addr    = alu_res;
      data_req.wdata   = rf_portb;
      data_req.bytesel = {4{store_en}};
      data_req.req     = ctrl.mem_read || store_en;
   end

   rv_decoder u_decoder (
      .instr (instr),
      .ctrl  (ctrl),
      .imm   (imm)
   );

   rv_alu u_alu (
      .alu_op   (ctrl.alu_op),
      .porta    (alu_porta),
      .portb    (alu_portb),
      .alu_res  (alu_res),
      .alu_cond (alu_cond)
   );

   rv_regfile #(.NUM_REGS(`RV_NUM_REGS)) u_regfile (
      .clk       (clk),
      .rst_n     (rst_n),
      .sel_porta (ctrl.rs1),
      .sel_portb (ctrl.rs2),
      .sel_rd    (ctrl.rd),
      .rd        (rd_data),
      .write_rd  (write_rd),
      .porta     (rf_porta),
      .portb     (rf_portb)
   );

   rv_flow_ctrl u_flow_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .code_rsp   (code_rsp),
      .data_ready (data_rsp.ready),
      .pc_sel     (ctrl.pc_sel),
      .mem_read   (ctrl.mem_read),
      .alu_cond   (alu_cond),
      .alu_res    (alu_res),
      .imm        (imm),
      .instr      (instr),
      .pc_exe     (pc_exe),
      .fetch_addr (fetch_addr),
      .stall_exe  (stall_exe)
   );

endmodule

`default_nettype wire

// File: rv_core_properties.sv
/* Core port assertions */

`timescale 1ns/1ps
`default_nettype none

module rv_core_properties import rv_core_pkg::*; (
   input logic      clk,
   input logic      rst_n,
   input code_req_t code_req,
   input data_req_t data_req,
   input data_rsp_t data_rsp
);

   bytesel_whole: assert property (@(posedge clk) disable iff (!rst_n)
      data_req.bytesel == 4'h0 || data_req.bytesel == 4'hf)
      else $error("bytesel is neither zero nor all ones");

   // First cycle out of reset is the RESET state
   no_req_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !data_req.req)
      else $error("data request right after reset release");

   fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      code_req.addr[1:0] == 2'b00)
      else $error("fetch address not word aligned");

   load_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (data_req.req && data_req.bytesel == 4'h0 && !data_rsp.ready)
      |=> (data_req.req && $stable(data_req.addr)))
      else $error("load address moved while waiting");

endmodule

`default_nettype wire

// File: rv_core_tb.sv
/* RV32I core testbench */

`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_core_tb import rv_core_pkg::*; ();

   localparam int NT   = 5;
   localparam int MAXP = 32;
   localparam int MAXS = 12;

   logic      clk = 1'b0;
   logic      rst_n = 1'b0;
   code_req_t code_req;
   code_rsp_t code_rsp = '0;
   data_req_t data_req;
   data_rsp_t data_rsp = '0;

   logic [31:0] cmem [256];
   logic [31:0] dmem [256];
   logic [31:0] code_addr_q = '0;
   logic        code_req_q = 1'b0;
   logic [31:0] lfsr = 32'h48e12a40;
   logic [31:0] st_addr [$];
   logic [31:0] st_data [$];

   // Test table
   string       tname [NT];
   logic [31:0] prog [NT][MAXP];
   int          plen [NT];
   logic [31:0] exp_addr [NT][MAXS];
   logic [31:0] exp_data [NT][MAXS];
   int          exp_cnt [NT];
   int          tests_built = 0;

   always #50 clk = !clk;

   rv_core u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .code_req (code_req),
      .code_rsp (code_rsp),
      .data_req (data_req),
      .data_rsp (data_rsp)
   );

   bind rv_core rv_core_properties u_properties (
      .clk      (clk),
      .rst_n    (rst_n),
      .code_req (code_req),
      .data_req (data_req),
      .data_rsp (data_rsp)
   );

   // ====================
   // Random source and memory models
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   always @(posedge clk) begin
      code_addr_q <= code_req.addr;
      code_req_q  <= code_req.req;
      if (rst_n && data_req.req && data_req.bytesel == 4'hf) begin
         st_addr.push_back(data_req.addr);
         st_data.push_back(data_req.wdata);
         dmem[data_req.addr[9:2]] <= data_req.wdata;
      end
   end

   // Word for last cycle's fetch address
   // Ready drops at random and stays low without a request
   always @(negedge clk) begin
      lfsr = lfsr_next(lfsr);
      code_rsp.ready <= lfsr[0] && code_req_q;
      code_rsp.rdata <= cmem[code_addr_q[9:2]];
      lfsr = lfsr_next(lfsr);
      data_rsp.ready <= lfsr[0] && data_req.req;
      data_rsp.rdata <= dmem[data_req.addr[9:2]];
   end

   // ====================
   // Instruction encoders
   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `RV_OPC_OP};
   endfunction

   function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                          input int rd, input int rs1, input int imm);
      return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
   endfunction

   function automatic logic [31:0] store_word(input int rs2, input int addr);
      logic [11:0] v;
      v = 12'(addr);
      return {v[11:5], 5'(rs2), 5'd0, 3'b010, v[4:0], `RV_OPC_STORE};
   endfunction

   function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                          input int imm);
      logic [12:0] v;
      v = 13'(imm);
      return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], `RV_OPC_BRANCH};
   endfunction

   function automatic logic [31:0] j_type(input int rd, input int imm);
      logic [20:0] v;
      v = 21'(imm);
      return {v[20], v[10:1], v[11], v[19:12], 5'(rd), `RV_OPC_JAL};
   endfunction

   task automatic put_instr(input int t, input logic [31:0] w);
      prog[t][plen[t]] = w;
      plen[t]++;
   endtask

   task automatic expect_store(input int t, input logic [31:0] a, input logic [31:0] d);
      exp_addr[t][exp_cnt[t]] = a;
      exp_data[t][exp_cnt[t]] = d;
      exp_cnt[t]++;
   endtask

   // Branch over one store of x3
   // The store shows up only when not taken
   task automatic branch_case(input int t, input logic [2:0] f3, input int rs1, input int rs2,
                              input int addr, input bit taken);
      put_instr(t, b_type(f3, rs1, rs2, 8));
      put_instr(t, store_word(3, addr));
      if (!taken) begin
         expect_store(t, addr, 32'h55);
      end
   endtask

   task automatic build_tests();
      for (int t = 0; t < NT; t++) begin
         plen[t] = 0;
         exp_cnt[t] = 0;
      end
      tname[0] = "alu_basic";
      put_instr(0, i_type(`RV_OPC_OP_IMM, 3'b000, 1, 0, 100));
      put_instr(0, i_type(`RV_OPC_OP_IMM, 3'b000, 2, 0, -7));
      put_instr(0, r_type(7'h00, 3'b000, 3, 1, 2));
      put_instr(0, r_type(7'h20, 3'b000, 4, 1, 2));
      put_instr(0, {20'h12345, 5'd5, `RV_OPC_LUI});
      put_instr(0, {20'h00001, 5'd6, `RV_OPC_AUIPC});
      put_instr(0, r_type(7'h00, 3'b100, 7, 5, 2));
      put_instr(0, r_type(7'h00, 3'b110, 8, 1, 5));
      put_instr(0, r_type(7'h00, 3'b111, 9, 2, 1));
      for (int r = 3; r <= 9; r++) begin
         put_instr(0, store_word(r, 'h100 + 4 * (r - 3)));
      end
      expect_store(0, 32'h100, 32'd93);
      expect_store(0, 32'h104, 32'd107);
      expect_store(0, 32'h108, 32'h12345000);
      expect_store(0, 32'h10c, 32'h00001014);
      expect_store(0, 32'h110, 32'hedcbaff9);
      expect_store(0, 32'h114, 32'h12345064);
      expect_store(0, 32'h118, 32'h00000060);

      tname[1] = "shift_compare";
      put_instr(1, i_type(`RV_OPC_OP_IMM, 3'b000, 1, 0, -16));
      put_instr(1, i_type(`RV_OPC_OP_IMM, 3'b000, 2, 0, 3));
      put_instr(1, r_type(7'h00, 3'b001, 3, 1, 2));
      put_instr(1, r_type(7'h00, 3'b101, 4, 1, 2));
      put_instr(1, r_type(7'h20, 3'b101, 5, 1, 2));
      put_instr(1, i_type(`RV_OPC_OP_IMM, 3'b101, 6, 1, 'h404));
      put_instr(1, i_type(`RV_OPC_OP_IMM, 3'b101, 7, 1, 28));
      put_instr(1, i_type(`RV_OPC_OP_IMM, 3'b001, 8, 2, 30));
      put_instr(1, r_type(7'h00, 3'b010, 9, 1, 2));
      put_instr(1, r_type(7'h00, 3'b011, 10, 1, 2));
      put_instr(1, i_type(`RV_OPC_OP_IMM, 3'b010, 11, 2, -1));
      put_instr(1, i_type(`RV_OPC_OP_IMM, 3'b011, 12, 2, -1));
      for (int r = 3; r <= 12; r++) begin
         put_instr(1, store_word(r, 'h100 + 4 * (r - 3)));
      end
      expect_store(1, 32'h100, 32'hffffff80);
      expect_store(1, 32'h104, 32'h1ffffffe);
      expect_store(1, 32'h108, 32'hfffffffe);
      expect_store(1, 32'h10c, 32'hffffffff);
      expect_store(1, 32'h110, 32'h0000000f);
      expect_store(1, 32'h114, 32'hc0000000);
      expect_store(1, 32'h118, 32'd1);
      expect_store(1, 32'h11c, 32'd0);
      expect_store(1, 32'h120, 32'd0);
      expect_store(1, 32'h124, 32'd1);

      tname[2] = "load_use";
      put_instr(2, {20'habcde, 5'd1, `RV_OPC_LUI});
      put_instr(2, i_type(`RV_OPC_OP_IMM, 3'b000, 1, 1, 'h123));
      put_instr(2, store_word(1, 'h180));
      put_instr(2, i_type(`RV_OPC_LOAD, 3'b010, 2, 0, 'h180));
      put_instr(2, r_type(7'h00, 3'b000, 4, 2, 2));
      put_instr(2, store_word(2, 'h100));
      put_instr(2, store_word(4, 'h104));
      expect_store(2, 32'h180, 32'habcde123);
      expect_store(2, 32'h100, 32'habcde123);
      expect_store(2, 32'h104, 32'h579bc246);

      // x1 = -1, x2 = 1, x3 = marker
      tname[3] = "branches";
      put_instr(3, i_type(`RV_OPC_OP_IMM, 3'b000, 1, 0, -1));
      put_instr(3, i_type(`RV_OPC_OP_IMM, 3'b000, 2, 0, 1));
      put_instr(3, i_type(`RV_OPC_OP_IMM, 3'b000, 3, 0, 'h55));
      branch_case(3, 3'b000, 1, 2, 'h100, 0);
      branch_case(3, 3'b001, 1, 2, 'h104, 1);
      branch_case(3, 3'b100, 1, 2, 'h108, 1);
      branch_case(3, 3'b101, 1, 2, 'h10c, 0);
      branch_case(3, 3'b110, 1, 2, 'h110, 0);
      branch_case(3, 3'b111, 1, 2, 'h114, 1);
      branch_case(3, 3'b000, 1, 1, 'h118, 1);
      branch_case(3, 3'b001, 2, 2, 'h11c, 0);
      branch_case(3, 3'b100, 2, 1, 'h120, 0);
      branch_case(3, 3'b101, 2, 1, 'h124, 1);
      branch_case(3, 3'b110, 2, 1, 'h128, 1);
      branch_case(3, 3'b111, 2, 1, 'h12c, 0);

      tname[4] = "jumps_x0";
      put_instr(4, j_type(1, 12));
      put_instr(4, store_word(1, 'h1f0));
      put_instr(4, store_word(1, 'h1f0));
      put_instr(4, store_word(1, 'h100));
      put_instr(4, i_type(`RV_OPC_OP_IMM, 3'b000, 5, 0, 33));
      put_instr(4, i_type(`RV_OPC_JALR, 3'b000, 6, 5, 0));
      put_instr(4, store_word(6, 'h1f4));
      put_instr(4, store_word(6, 'h1f4));
      put_instr(4, store_word(6, 'h104));
      put_instr(4, i_type(`RV_OPC_OP_IMM, 3'b000, 0, 0, 77));
      put_instr(4, store_word(0, 'h108));
      expect_store(4, 32'h100, 32'd4);
      expect_store(4, 32'h104, 32'd24);
      expect_store(4, 32'h108, 32'd0);

      // Every program parks on a jump to itself
      for (int t = 0; t < NT; t++) begin
         put_instr(t, j_type(0, 0));
      end
   endtask

   // ====================
   // Watchdog
   initial begin
      int limit;
      wait (tests_built != 0);
      limit = 0;
      for (int t = 0; t < NT; t++) begin
         limit += plen[t] * 16 + 200 + 40;
      end
      repeat (limit) @(posedge clk);
      $display("Watchdog expired, the run did not finish in %0d cycles", limit);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // ====================
   // Test loop
   initial begin
      int n_pass;
      int n_fail;
      int cycles;
      bit bad;
      n_pass = 0;
      n_fail = 0;
      for (int i = 0; i < 256; i++) begin
         dmem[i] = 32'h5a5a0000 ^ (i * 4);
      end
      build_tests();
      tests_built = 1;
      for (int t = 0; t < NT; t++) begin
         bad = 0;
         @(negedge clk);
         rst_n = 1'b0;
         for (int i = 0; i < 256; i++) begin
            cmem[i] = (i < plen[t]) ? prog[t][i] : `RV_NOP;
         end
         st_addr.delete();
         st_data.delete();
         repeat (16) @(negedge clk);
         rst_n = 1'b1;
         cycles = 0;
         while (st_addr.size() < exp_cnt[t] && cycles < plen[t] * 16 + 200) begin
            @(negedge clk);
            cycles++;
         end
         repeat (20) @(negedge clk);
         for (int k = 0; k < exp_cnt[t]; k++) begin
            if (k >= st_addr.size()) begin
               $display("%s: store %0d to address %h never appeared", tname[t], k,
                        exp_addr[t][k]);
               bad = 1;
            end else if (st_addr[k] != exp_addr[t][k] || st_data[k] != exp_data[t][k]) begin
               $display("[FAIL] %s store %0d expected %h=%h actual %h=%h", tname[t], k,
                        exp_addr[t][k], exp_data[t][k], st_addr[k], st_data[k]);
               bad = 1;
            end
         end
         if (st_addr.size() > exp_cnt[t]) begin
            $display("%s: %0d stores seen where %0d were expected", tname[t],
                     st_addr.size(), exp_cnt[t]);
            bad = 1;
         end
         if (bad) begin
            n_fail++;
            $display("%s finished with errors", tname[t]);
         end else begin
            n_pass++;
            $display("[PASS] %s", tname[t]);
         end
      end
      $display("Tests passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
rv_core_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_flow_ctrl.sv
rv_core.sv
rv_core_properties.sv
rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator and run, pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
   -f files.f -o rv_core_sim &&
./obj_dir/rv_core_sim | tee /dev/stderr | grep -qx "TEST RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
